// ==== build.f ====
hw/cpu_pkg.sv
hw/program_counter.sv
hw/mem_port.sv
hw/datapath.sv
hw/control_fsm.sv
hw/cpu_top.sv
test/cpu_mem_model.sv
test/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_cpu -f build.f -o tb_cpu

./obj_dir/tb_cpu

// ==== test/cpu_trace.txt ====
// columns in hex: kind address value
// kind 1 preload word, 2 input value, 3 expected out, 4 expected final memory word
1 00 0005
1 01 0003
1 02 1234
1 03 0100
// program from address 8
1 08 0400
1 09 1501
1 0a 2610
1 0b 3723
1 0c 7300
1 0d 8600
1 0e 8700
1 0f 1235
1 10 8200
1 11 3033
1 12 8000
1 13 f000
2 00 beef
// out values in strobe order
3 00 fffe
3 00 3400
3 00 bef7
3 00 a321
// data words after STOP
4 00 a321
4 01 0003
4 02 bef7
4 03 beef
4 04 0005
4 05 0008
4 06 fffe
4 07 3400

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

    localparam int DATA_WIDTH       = 16;
    localparam int ADDR_WIDTH       = 6;
    localparam int START_PC         = 8;
    localparam int TRACE_WORDS      = 192;
    localparam int POST_HALT_CYCLES = 20;

    logic                  clk;
    logic                  rst_n;
    logic [DATA_WIDTH-1:0] in;
    logic                  mem_ack;
    logic [DATA_WIDTH-1:0] mem_rdata;
    logic                  mem_req;
    logic                  mem_we;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic [DATA_WIDTH-1:0] out;
    logic                  out_strobe;
    logic                  halted;
    logic                  protocol_error;

    // each trace line gives kind, address and value as three words
    logic [DATA_WIDTH-1:0] trace [TRACE_WORDS];
    logic [DATA_WIDTH-1:0] exp_outs [$];
    logic [ADDR_WIDTH-1:0] final_addrs [$];
    logic [DATA_WIDTH-1:0] final_words [$];

    int out_count;
    int cycle_count;
    int cycle_limit;
    int n_instr;
    bit first_req_seen;

    cpu_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .START_PC   (START_PC)
    ) cpu_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (in),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .out        (out),
        .out_strobe (out_strobe),
        .halted     (halted)
    );

    cpu_mem_model #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .SEED       (40)
    ) mem_model_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_ack        (mem_ack),
        .mem_rdata      (mem_rdata),
        .protocol_error (protocol_error)
    );

    always #5 clk = ~clk;

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_out(input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t signal=out expected=%h actual=%h", $time, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_mem(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t signal=mem[%0d] expected=%h actual=%h",
                     $time, addr, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_addr(input string name,
                              input logic [ADDR_WIDTH-1:0] expected,
                              input logic [ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            fail_run();
        end
    endtask

    task automatic apply_trace();
        for (int i = 0; i + 2 < TRACE_WORDS && trace[i] != 16'h0; i += 3) begin
            case (trace[i])
                16'h1: begin
                    mem_model_i.mem[trace[i+1][ADDR_WIDTH-1:0]] = trace[i+2];
                    if (int'(trace[i+1]) >= START_PC) begin
                        n_instr++;
                    end
                end
                16'h2: in = trace[i+2];
                16'h3: exp_outs.push_back(trace[i+2]);
                16'h4: begin
                    final_addrs.push_back(trace[i+1][ADDR_WIDTH-1:0]);
                    final_words.push_back(trace[i+2]);
                end
                default: begin
                    $display("trace holds an unknown line kind %h", trace[i]);
                    fail_run();
                end
            endcase
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in          = '0;
        out_count   = 0;
        cycle_count = 0;
        cycle_limit = 0;
        n_instr     = 0;
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace[i] = '0;
        end
        $readmemh("test/cpu_trace.txt", trace);

        @(negedge clk);
        apply_trace();
        // each instruction gets up to 6 accesses of 12 cycles
        cycle_limit = n_instr * 6 * 12 + 2 + POST_HALT_CYCLES;
        check_bit("mem_req", 1'b0, mem_req);
        check_bit("mem_we", 1'b0, mem_we);
        check_bit("out_strobe", 1'b0, out_strobe);
        check_bit("halted", 1'b0, halted);
        check_out('0, out);

        @(negedge clk);
        rst_n = 1'b1;

        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        if (out_count != exp_outs.size()) begin
            $display("saw %0d out strobes but the trace expects %0d", out_count, exp_outs.size());
            fail_run();
        end

        // core must stay parked with the bus quiet
        repeat (POST_HALT_CYCLES) begin
            @(negedge clk);
            check_bit("halted", 1'b1, halted);
            check_bit("mem_req", 1'b0, mem_req);
        end

        for (int k = 0; k < final_addrs.size(); k++) begin
            check_mem(final_addrs[k], final_words[k], mem_model_i.mem[final_addrs[k]]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

    always @(negedge clk) begin
        if (rst_n && out_strobe === 1'b1) begin
            if (out_count >= exp_outs.size()) begin
                $display("out strobe at %0t has no expected value left", $time);
                fail_run();
            end else begin
                check_out(exp_outs[out_count], out);
                out_count++;
            end
        end
    end

    // first bus access is the fetch read of the start address
    always @(negedge clk) begin
        if (rst_n && !first_req_seen && mem_req === 1'b1) begin
            first_req_seen = 1'b1;
            check_addr("mem_addr", ADDR_WIDTH'(START_PC), mem_addr);
            check_bit("mem_we", 1'b0, mem_we);
        end
    end

    always @(negedge clk) begin
        if (protocol_error === 1'b1) begin
            $display("the memory model saw a four-phase handshake violation");
            fail_run();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles without finishing the program", cycle_limit);
            fail_run();
        end
    end

endmodule

// ==== test/cpu_mem_model.sv ====
`timescale 1ns/1ns

module cpu_mem_model #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16,
    parameter int SEED       = 40
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req,
    input  logic                  mem_we,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [DATA_WIDTH-1:0] mem_wdata,
    output logic                  mem_ack,
    output logic [DATA_WIDTH-1:0] mem_rdata,
    output logic                  protocol_error
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_WAIT_UP,
        M_ACK,
        M_WAIT_DOWN
    } phase_e;

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
    phase_e                phase;
    logic [1:0]            wait_cnt;
    logic [31:0]           rng;

    // request fields seen at the previous edge
    logic                  last_req;
    logic                  last_ack;
    logic                  last_we;
    logic [ADDR_WIDTH-1:0] last_addr;
    logic [DATA_WIDTH-1:0] last_wdata;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every word starts out different, preload overrides it
    initial begin
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            mem[i] = DATA_WIDTH'((i * 32'h0000_0101) ^ 32'h0000_5A3C);
        end
    end

    task automatic serve_access();
        if (mem_we) begin
            mem[mem_addr] = mem_wdata;
        end else begin
            mem_rdata <= mem[mem_addr];
        end
        mem_ack <= 1'b1;
        phase   <= M_ACK;
    endtask

    // ack rises and falls after 0 to 3 extra cycles
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= M_IDLE;
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            wait_cnt  <= 2'd0;
            rng       <= 32'(SEED);
        end else begin
            case (phase)
                M_IDLE: begin
                    if (mem_req) begin
                        rng <= xorshift32(rng);
                        if (rng[1:0] == 2'd0) begin
                            serve_access();
                        end else begin
                            wait_cnt <= rng[1:0] - 2'd1;
                            phase    <= M_WAIT_UP;
                        end
                    end
                end
                M_WAIT_UP: begin
                    if (wait_cnt == 2'd0) begin
                        serve_access();
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                M_ACK: begin
                    if (!mem_req) begin
                        rng <= xorshift32(rng);
                        if (rng[1:0] == 2'd0) begin
                            mem_ack <= 1'b0;
                            phase   <= M_IDLE;
                        end else begin
                            wait_cnt <= rng[1:0] - 2'd1;
                            phase    <= M_WAIT_DOWN;
                        end
                    end
                end
                M_WAIT_DOWN: begin
                    if (wait_cnt == 2'd0) begin
                        mem_ack <= 1'b0;
                        phase   <= M_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
            endcase
        end
    end

    // four-phase rules seen from the slave side
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_req       <= 1'b0;
            last_ack       <= 1'b0;
            protocol_error <= 1'b0;
        end else begin
            last_req   <= mem_req;
            last_ack   <= mem_ack;
            last_we    <= mem_we;
            last_addr  <= mem_addr;
            last_wdata <= mem_wdata;
            if (last_req && !mem_req && !last_ack) begin
                $display("memory model: request dropped before acknowledge at %0t", $time);
                protocol_error <= 1'b1;
            end
            if (!last_req && mem_req && mem_ack) begin
                $display("memory model: request raised while acknowledge high at %0t", $time);
                protocol_error <= 1'b1;
            end
            if (last_req && mem_req && (mem_addr !== last_addr || mem_we !== last_we ||
                                        mem_wdata !== last_wdata)) begin
                $display("memory model: request fields changed during request at %0t", $time);
                protocol_error <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top #(
    parameter int DATA_WIDTH = 16,
    parameter int ADDR_WIDTH = 6,
    parameter int START_PC   = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] in,
    input  logic                  mem_ack,
    input  logic [DATA_WIDTH-1:0] mem_rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0] mem_wdata,
    output logic [DATA_WIDTH-1:0] out,
    output logic                  out_strobe,
    output logic                  halted
);

    import cpu_pkg::*;

    // sequencer controls
    logic      start;
    logic      we;
    logic      done;
    logic      pc_inc;
    logic      ir_ld;
    logic      acc_ld_mem;
    logic      acc_ld_alu;
    logic      out_ld;
    addr_sel_e addr_sel;

    // decode feedback
    opcode_e opcode;
    logic    operand_ok;

    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH-1:0] rdata;

    control_fsm control_fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .operand_ok (operand_ok),
        .done       (done),
        .start      (start),
        .we         (we),
        .pc_inc     (pc_inc),
        .ir_ld      (ir_ld),
        .acc_ld_mem (acc_ld_mem),
        .acc_ld_alu (acc_ld_alu),
        .out_ld     (out_ld),
        .halted     (halted),
        .addr_sel   (addr_sel)
    );

    program_counter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .START_PC   (START_PC)
    ) program_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (pc_inc),
        .pc    (pc)
    );

    mem_port #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) mem_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .done      (done),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    datapath #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) datapath_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ir_ld      (ir_ld),
        .acc_ld_mem (acc_ld_mem),
        .acc_ld_alu (acc_ld_alu),
        .out_ld     (out_ld),
        .addr_sel   (addr_sel),
        .pc         (pc),
        .rdata      (rdata),
        .in         (in),
        .opcode     (opcode),
        .operand_ok (operand_ok),
        .addr       (addr),
        .wdata      (wdata),
        .out        (out),
        .out_strobe (out_strobe)
    );

endmodule

// ==== hw/control_fsm.sv ====
`timescale 1ns/1ns

module control_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::opcode_e    opcode,
    input  logic                operand_ok,
    input  logic                done,
    output logic                start,
    output logic                we,
    output logic                pc_inc,
    output logic                ir_ld,
    output logic                acc_ld_mem,
    output logic                acc_ld_alu,
    output logic                out_ld,
    output logic                halted,
    output cpu_pkg::addr_sel_e  addr_sel
);

    import cpu_pkg::*;

    state_e state;
    state_e state_next;
    logic   pending;
    logic   access_state;

    // states that own exactly one memory access
    assign access_state = (state == FETCH) || (state == READ_B) || (state == READ_C) ||
                          (state == WRITE) || (state == OUTPUT);

    // first cycle of an access state issues the request
    assign start  = access_state && !pending;
    assign we     = (state == WRITE);
    assign halted = (state == HALT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= FETCH;
            pending <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
        end
    end

    always_comb begin
        state_next = state;
        pc_inc     = 1'b0;
        ir_ld      = 1'b0;
        acc_ld_mem = 1'b0;
        acc_ld_alu = 1'b0;
        out_ld     = 1'b0;
        addr_sel   = ADDR_PC;
        case (state)
            FETCH: begin
                if (done) begin
                    ir_ld      = 1'b1;
                    pc_inc     = 1'b1;
                    state_next = DECODE;
                end
            end
            DECODE: begin
                if (!operand_ok) begin
                    state_next = HALT;
                end else begin
                    case (opcode)
                        OP_MOV, OP_ADD, OP_SUB, OP_MUL: state_next = READ_B;
                        OP_IN:                          state_next = WRITE;
                        OP_OUT:                         state_next = OUTPUT;
                        default:                        state_next = HALT;
                    endcase
                end
            end
            READ_B: begin
                addr_sel = ADDR_A2;
                if (done) begin
                    acc_ld_mem = 1'b1;
                    // MOV only copies while arithmetic still needs its second operand
                    state_next = (opcode == OP_MOV) ? WRITE : READ_C;
                end
            end
            READ_C: begin
                addr_sel = ADDR_A3;
                if (done) begin
                    state_next = EXECUTE;
                end
            end
            EXECUTE: begin
                // rdata still holds the A3 operand here
                acc_ld_alu = 1'b1;
                state_next = WRITE;
            end
            WRITE: begin
                addr_sel = ADDR_A1;
                if (done) begin
                    state_next = FETCH;
                end
            end
            OUTPUT: begin
                addr_sel = ADDR_A1;
                if (done) begin
                    out_ld     = 1'b1;
                    state_next = FETCH;
                end
            end
            HALT: begin
                state_next = HALT;
            end
            default: begin
                state_next = HALT;
            end
        endcase
    end

    // only one access in flight so the next start waits for the previous done
    a_single_access: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> (!start throughout done[->1]));

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        (state == HALT) |=> (state == HALT));

    // a data access never runs with an indirect operand field
    a_no_indirect_access: assert property (@(posedge clk) disable iff (!rst_n)
        (start && (state != FETCH)) |-> operand_ok);

endmodule

// ==== hw/datapath.sv ====
`timescale 1ns/1ns

module datapath #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ir_ld,
    input  logic                  acc_ld_mem,
    input  logic                  acc_ld_alu,
    input  logic                  out_ld,
    input  cpu_pkg::addr_sel_e    addr_sel,
    input  logic [ADDR_WIDTH-1:0] pc,
    input  logic [DATA_WIDTH-1:0] rdata,
    input  logic [DATA_WIDTH-1:0] in,
    output cpu_pkg::opcode_e      opcode,
    output logic                  operand_ok,
    output logic [ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] out,
    output logic                  out_strobe
);

    import cpu_pkg::*;

    logic [DATA_WIDTH-1:0] ir;
    logic [DATA_WIDTH-1:0] acc;
    logic [DATA_WIDTH-1:0] alu_result;
    logic [FIELD_BITS-1:0] a1;
    logic [FIELD_BITS-1:0] a2;
    logic [FIELD_BITS-1:0] a3;

    // low field bits select one of the eight data words
    function automatic logic [ADDR_WIDTH-1:0] data_addr(input logic [FIELD_BITS-1:0] field);
        return {{(ADDR_WIDTH-DATA_ADDR_BITS){1'b0}}, field[DATA_ADDR_BITS-1:0]};
    endfunction

    assign opcode = opcode_e'(ir[OPCODE_LSB +: OPCODE_BITS]);
    assign a1     = ir[A1_LSB +: FIELD_BITS];
    assign a2     = ir[A2_LSB +: FIELD_BITS];
    assign a3     = ir[A3_LSB +: FIELD_BITS];

    // top bit of a field is the indirect flag, only checked on fields in use
    always_comb begin
        case (opcode)
            OP_MOV:                 operand_ok = !a1[FIELD_BITS-1] && !a2[FIELD_BITS-1];
            OP_ADD, OP_SUB, OP_MUL: operand_ok = !a1[FIELD_BITS-1] && !a2[FIELD_BITS-1] &&
                                                 !a3[FIELD_BITS-1];
            OP_IN, OP_OUT:          operand_ok = !a1[FIELD_BITS-1];
            default:                operand_ok = 1'b1;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ADD:  alu_result = acc + rdata;
            OP_SUB:  alu_result = acc - rdata;
            OP_MUL:  alu_result = acc * rdata;
            default: alu_result = acc;
        endcase
    end

    always_comb begin
        case (addr_sel)
            ADDR_A1: addr = data_addr(a1);
            ADDR_A2: addr = data_addr(a2);
            ADDR_A3: addr = data_addr(a3);
            default: addr = pc;
        endcase
    end

    assign wdata = (opcode == OP_IN) ? in : acc;

    always_ff @(posedge clk) begin
        if (ir_ld) begin
            ir <= rdata;
        end
        if (acc_ld_mem) begin
            acc <= rdata;
        end else if (acc_ld_alu) begin
            acc <= alu_result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out        <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= out_ld;
            if (out_ld) begin
                out <= rdata;
            end
        end
    end

endmodule

// ==== hw/mem_port.sv ====
`timescale 1ns/1ns

module mem_port #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0] mem_wdata,
    input  logic                  mem_ack,
    input  logic [DATA_WIDTH-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_REQ,
        PH_RELEASE
    } phase_e;

    phase_e phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= PH_IDLE;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        mem_req <= 1'b1;
                        mem_we  <= we;
                        phase   <= PH_REQ;
                    end
                end
                PH_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        mem_we  <= 1'b0;
                        phase   <= PH_RELEASE;
                    end
                end
                PH_RELEASE: begin
                    // slave has to let go of ack before the access counts as finished
                    if (!mem_ack) begin
                        done  <= 1'b1;
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && start) begin
            mem_addr  <= addr;
            mem_wdata <= wdata;
        end
        // read data is only valid while ack is high
        if (phase == PH_REQ && mem_ack && !mem_we) begin
            rdata <= mem_rdata;
        end
    end

    a_req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_req) |-> $past(mem_ack));

endmodule

// ==== hw/program_counter.sv ====
`timescale 1ns/1ns

module program_counter #(
    parameter int ADDR_WIDTH = 6,
    parameter int START_PC   = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inc,
    output logic [ADDR_WIDTH-1:0] pc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= ADDR_WIDTH'(START_PC);
        end else if (inc) begin
            pc <= pc + 1'b1;
        end
    end

    // program must stop before running off the end of memory
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        inc |=> (pc != '0));

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    // instruction word layout: opcode, then three operand fields
    localparam int OPCODE_BITS    = 4;
    localparam int FIELD_BITS     = 4;
    localparam int DATA_ADDR_BITS = 3;

    localparam int OPCODE_LSB = 12;
    localparam int A1_LSB     = 8;
    localparam int A2_LSB     = 4;
    localparam int A3_LSB     = 0;

    typedef enum logic [OPCODE_BITS-1:0] {
        OP_MOV  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_IN   = 4'd7,
        OP_OUT  = 4'd8,
        OP_STOP = 4'd15
    } opcode_e;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        READ_B,
        READ_C,
        EXECUTE,
        WRITE,
        OUTPUT,
        HALT
    } state_e;

    // source of the memory address for the current access
    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_A1,
        ADDR_A2,
        ADDR_A3
    } addr_sel_e;

endpackage
